// File: src.f
sdPkg.sv
spiShifter.sv
sdController.sv
blockBuffer.sv
axiLiteRegs.sv
sdReader.sv
sdCardModel.sv
tbSdReader.sv

// File: run.sh
#!/usr/bin/env bash
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbSdReader \
    && ./obj_dir/VtbSdReader | tee /dev/stderr | grep -qx "SIMULATION PASSED" \
    || exit 1

// File: tbSdReader.sv
module tbSdReader import sdPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_NS = 2 * CLK_DIV * 20;       // One sdClk period
    localparam int BYTES_PER_RUN = 12 * 16 + BLOCK_WORDS * 6 + 64;
    localparam int RUN_NS = 2 * BYTES_PER_RUN * 8 * BIT_NS;
    localparam int RUNS = 5;
    localparam int WATCHDOG_NS = (RUNS + 2) * RUN_NS;
    localparam int AXI_WAIT = 50;                   // Cycles before a handshake is lost

    logic         clk = 1'b0;
    logic         rstN;
    axiLiteReq_t  axiReq;
    axiLiteResp_t axiResp;
    logic         sdClk;
    logic         sdCs;
    logic         sdMosi;
    logic         sdMiso;
    logic         mute;
    logic [7:0]   busyRepeats;

    int          seed = 32'h520a_7544;
    int          errorCount = 0;
    int          testCount = 0;
    int          testStartErrors = 0;
    logic [31:0] lastRead;
    string       expName [$];
    logic [31:0] expData [$];
    logic [31:0] expMask [$];
    string       cmpName;
    logic [31:0] cmpData;
    logic [31:0] cmpMask;

    sdReader i_sdReader (
        .clk(clk), .rstN(rstN), .axiReq(axiReq), .axiResp(axiResp),
        .sdClk(sdClk), .sdCs(sdCs), .sdMosi(sdMosi), .sdMiso(sdMiso)
    );

    sdCardModel i_sdCardModel (
        .clk(clk), .sdClk(sdClk), .sdCs(sdCs), .sdMosi(sdMosi), .sdMiso(sdMiso),
        .mute(mute), .busyRepeats(busyRepeats)
    );

    always #10 clk = ~clk;

    // Card data byte is block low byte plus index, XOR half the index
    function automatic logic [7:0] blockByte(input logic [31:0] blk, input int idx);
        logic [8:0] i9;
        i9 = idx[8:0];
        return 8'(blk[7:0] + i9[7:0]) ^ i9[8:1];
    endfunction

    // Each read response is compared with the expectation queued for it
    always @(posedge clk) begin
        if (rstN && axiResp.rvalid && axiReq.rready) begin
            if (axiResp.rresp != 2'b00) begin
                $display("CHECK FAILED rresp: got 0x%0h, expected 0x0", axiResp.rresp);
                errorCount++;
            end
            if (expData.size() == 0) begin
                $display("Read data 0x%08h arrived with nothing expected", axiResp.rdata);
                errorCount++;
            end else begin
                cmpName = expName.pop_front();
                cmpData = expData.pop_front();
                cmpMask = expMask.pop_front();
                if ((axiResp.rdata & cmpMask) != (cmpData & cmpMask)) begin
                    $display("CHECK FAILED rdata (%s): got 0x%08h, expected 0x%08h",
                             cmpName, axiResp.rdata & cmpMask, cmpData & cmpMask);
                    errorCount++;
                end
            end
            lastRead = axiResp.rdata;
        end
    end

    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data);
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        axiReq.awaddr = addr;
        axiReq.awvalid = 1'b1;
        axiReq.wdata = data;
        axiReq.wstrb = 4'hF;
        axiReq.wvalid = 1'b1;
        while (!(axiResp.awready && axiResp.wready) && waitCycles < AXI_WAIT) begin
            @(negedge clk);
            waitCycles++;
        end
        @(negedge clk);                             // Taken on the rising edge before
        axiReq.awvalid = 1'b0;
        axiReq.wvalid = 1'b0;
        while (!axiResp.bvalid && waitCycles < AXI_WAIT) begin
            @(negedge clk);
            waitCycles++;
        end
        if (axiResp.bvalid && axiResp.bresp != 2'b00) begin
            $display("CHECK FAILED bresp: got 0x%0h, expected 0x0", axiResp.bresp);
            errorCount++;
        end
        if (waitCycles >= AXI_WAIT) begin
            $display("AXI write to 0x%08h was never acknowledged", addr);
            errorCount++;
        end
    endtask

    task automatic axiRead(input logic [31:0] addr, input string name,
                           input logic [31:0] exp, input logic [31:0] mask);
        int waitCycles;
        waitCycles = 0;
        expName.push_back(name);
        expData.push_back(exp);
        expMask.push_back(mask);
        @(negedge clk);
        axiReq.araddr = addr;
        axiReq.arvalid = 1'b1;
        while (!axiResp.arready && waitCycles < AXI_WAIT) begin
            @(negedge clk);
            waitCycles++;
        end
        @(negedge clk);
        axiReq.arvalid = 1'b0;
        while (!axiResp.rvalid && waitCycles < AXI_WAIT) begin
            @(negedge clk);
            waitCycles++;
        end
        @(negedge clk);                             // Compare done on this rising edge
        if (waitCycles >= AXI_WAIT) begin
            $display("AXI read from 0x%08h returned no data", addr);
            errorCount++;
            expName.delete();
            expData.delete();
            expMask.delete();
        end
    endtask

    task automatic startRun(input logic [31:0] blk);
        axiWrite(REG_BLOCK, blk);
        axiWrite(REG_CTRL, 32'h1);
    endtask

    // Poll status until busy drops, bounded by the worst-case run time
    task automatic waitRun();
        longint deadline;
        logic stillBusy;
        deadline = $time + RUN_NS;
        stillBusy = 1'b1;
        while (stillBusy && $time < deadline) begin
            repeat (100) @(negedge clk);
            axiRead(REG_STATUS, "REG_STATUS reserved", 32'h0, 32'hFFFF_FFF8);
            stillBusy = lastRead[0];
        end
        if (stillBusy) begin
            $display("Run was still busy after %0d ns", RUN_NS);
            errorCount++;
        end
    endtask

    task automatic checkBlock(input logic [31:0] blk);
        logic [31:0] word;
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            word = {blockByte(blk, 4 * k), blockByte(blk, 4 * k + 1),
                    blockByte(blk, 4 * k + 2), blockByte(blk, 4 * k + 3)};
            axiRead(BUF_BASE + 32'(4 * k), $sformatf("buffer word %0d", k), word, '1);
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == testStartErrors) begin
            $display("Test %0d %s: ok", testCount, name);
        end else begin
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] blkA;
        logic [31:0] blkB;
        logic [31:0] blkC;
        rstN = 1'b0;
        axiReq = '0;
        axiReq.bready = 1'b1;
        axiReq.rready = 1'b1;
        mute = 1'b0;
        busyRepeats = 8'd0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;

        axiRead(REG_STATUS, "REG_STATUS", 32'h0, '1);
        axiRead(BUF_BASE, "buffer word 0", 32'h0, '1);
        axiRead(BUF_BASE + 32'h1FC, "buffer word 127", 32'h0, '1);
        finishTest("reset state");

        busyRepeats = 8'd2;
        blkA = $random(seed);
        startRun(blkA);
        waitRun();
        axiRead(REG_STATUS, "REG_STATUS", 32'h2, '1);
        checkBlock(blkA);
        finishTest("block read");

        blkB = $random(seed);
        axiWrite(REG_BLOCK, blkB);
        axiRead(REG_BLOCK, "REG_BLOCK", blkB, '1);
        finishTest("block number readback");

        blkA = $random(seed);
        blkB = $random(seed);
        if (blkB[7:0] == blkA[7:0]) begin
            blkB = blkB ^ 32'h1;                    // A restart must show in the data
        end
        startRun(blkA);
        axiWrite(REG_BLOCK, blkB);
        axiWrite(REG_CTRL, 32'h1);                  // Lands while the run is busy
        axiRead(REG_STATUS, "REG_STATUS", 32'h1, '1);
        waitRun();
        axiRead(REG_STATUS, "REG_STATUS", 32'h2, '1);
        axiRead(REG_BLOCK, "REG_BLOCK", blkB, '1);
        checkBlock(blkA);
        finishTest("start while busy");

        mute = 1'b1;
        startRun($random(seed));
        waitRun();
        axiRead(REG_STATUS, "REG_STATUS", 32'h4, '1);
        mute = 1'b0;
        blkC = $random(seed);
        startRun(blkC);
        waitRun();
        axiRead(REG_STATUS, "REG_STATUS", 32'h2, '1);
        finishTest("muted card");

        busyRepeats = 8'd1;
        blkA = $random(seed);
        if (blkA[7:0] == blkC[7:0]) begin
            blkA = blkA ^ 32'h1;                    // Keep the data distinct
        end
        startRun(blkA);
        waitRun();
        axiRead(REG_STATUS, "REG_STATUS", 32'h2, '1);
        checkBlock(blkA);
        finishTest("second block");

        $display("Tests run: %0d, failed checks: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sdCardModel.sv
module sdCardModel import sdPkg::*; (
    input  logic       clk,
    input  logic       sdClk,
    input  logic       sdCs,
    input  logic       sdMosi,
    output logic       sdMiso,
    input  logic       mute,          // Card never answers
    input  logic [7:0] busyRepeats    // ACMD41 answers busy this many times
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        clkSeen = 1'b0;
    logic [47:0] cmdShift = '0;
    int          cmdBits = 0;
    logic [7:0]  txShift = 8'hFF;
    int          bitsLeft = 0;
    logic        inIdle = 1'b1;
    int          acmdCount = 0;
    logic        misoR = 1'b1;
    logic [7:0]  txQ [$];

    assign sdMiso = misoR;

    function automatic logic [7:0] patternByte(input logic [31:0] blk, input logic [8:0] idx);
        return (blk[7:0] + idx[7:0]) ^ idx[8:1];
    endfunction

    task automatic queueResponse(input logic [5:0] idx, input logic [31:0] arg);
        txQ.push_back(8'hFF);                 // One byte of Ncr gap
        case (idx)
            6'd0: begin
                inIdle = 1'b1;
                acmdCount = 0;
                txQ.push_back(8'h01);
            end
            6'd8: begin
                txQ.push_back(8'h01);
                txQ.push_back(8'h00);
                txQ.push_back(8'h00);
                txQ.push_back(arg[15:8]);     // Voltage and check pattern echo
                txQ.push_back(arg[7:0]);
            end
            6'd55: txQ.push_back({7'd0, inIdle});
            6'd41: begin
                if (acmdCount < int'(busyRepeats)) begin
                    acmdCount++;
                    txQ.push_back(8'h01);
                end else begin
                    inIdle = 1'b0;
                    txQ.push_back(8'h00);
                end
            end
            6'd16: txQ.push_back(8'h00);
            6'd17: begin
                txQ.push_back(8'h00);
                repeat (3) txQ.push_back(8'hFF);  // Access time before the token
                txQ.push_back(8'hFE);
                for (int i = 0; i < 512; i++) begin
                    txQ.push_back(patternByte(arg, 9'(i)));
                end
                txQ.push_back(8'h3C);             // CRC16 bytes, never checked
                txQ.push_back(8'hC3);
            end
            default: txQ.push_back(8'h04);        // Illegal command
        endcase
    endtask

    // SPI pins are seen one system clock after the host moves them
    always @(posedge clk) begin
        if (sdCs) begin
            cmdBits = 0;
        end else if (sdClk && !clkSeen) begin
            if (bitsLeft > 0) begin
                txShift = {txShift[6:0], 1'b1};   // Host took this bit
                bitsLeft--;
            end
            if (cmdBits != 0 || !sdMosi) begin
                cmdShift = {cmdShift[46:0], sdMosi};
                cmdBits++;
                if (cmdBits == 48) begin
                    cmdBits = 0;
                    if (!mute) begin
                        queueResponse(cmdShift[45:40], cmdShift[39:8]);
                    end
                end
            end
        end
        clkSeen = sdClk;
        if (bitsLeft == 0 && txQ.size() > 0) begin
            txShift = txQ.pop_front();
            bitsLeft = 8;
        end
        misoR <= txShift[7];
    end

endmodule

// File: sdReader.sv
module sdReader import sdPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  axiLiteReq_t  axiReq,
    output axiLiteResp_t axiResp,
    output logic         sdClk,
    output logic         sdCs,
    output logic         sdMosi,
    input  logic         sdMiso
);
    logic                   start;
    logic [31:0]            blockNum;
    logic                   busy;
    logic                   done;
    logic                   error;
    spiJob_t                job;
    logic                   jobValid;
    logic                   jobBusy;
    logic                   jobDone;
    logic [39:0]            respData;
    logic                   timedOut;
    logic                   byteValid;
    logic [7:0]             rxByte;
    logic                   wrEn;
    logic [WORD_ADDR_W-1:0] wrAddr;
    logic [31:0]            wrData;
    logic [WORD_ADDR_W-1:0] rdAddr;
    logic [31:0]            rdData;

    spiShifter i_spiShifter (
        .clk(clk), .rstN(rstN), .job(job), .jobValid(jobValid), .jobBusy(jobBusy),
        .jobDone(jobDone), .respData(respData), .timedOut(timedOut),
        .byteValid(byteValid), .rxByte(rxByte),
        .sdClk(sdClk), .sdCs(sdCs), .sdMosi(sdMosi), .sdMiso(sdMiso)
    );

    sdController i_sdController (
        .clk(clk), .rstN(rstN), .start(start), .blockNum(blockNum),
        .busy(busy), .done(done), .error(error),
        .job(job), .jobValid(jobValid), .jobBusy(jobBusy), .jobDone(jobDone),
        .respData(respData), .timedOut(timedOut), .byteValid(byteValid), .rxByte(rxByte),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    blockBuffer i_blockBuffer (
        .clk(clk), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdAddr(rdAddr), .rdData(rdData)
    );

    axiLiteRegs i_axiLiteRegs (
        .clk(clk), .rstN(rstN), .axiReq(axiReq), .axiResp(axiResp),
        .start(start), .blockNum(blockNum), .busy(busy), .done(done), .error(error),
        .rdAddr(rdAddr), .rdData(rdData)
    );

endmodule

// File: axiLiteRegs.sv
module axiLiteRegs import sdPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  axiLiteReq_t            axiReq,
    output axiLiteResp_t           axiResp,
    output logic                   start,
    output logic [31:0]            blockNum,
    input  logic                   busy,
    input  logic                   done,
    input  logic                   error,
    output logic [WORD_ADDR_W-1:0] rdAddr,
    input  logic [31:0]            rdData
);
    logic        bvalid;
    logic        rvalid;
    logic        rdPend;
    logic        wrFire;
    logic        rdFire;
    logic [31:0] rdSel;
    logic [31:0] rdataR;

    function automatic logic inBuffer(input logic [31:0] addr);
        return (addr & ~32'(BLOCK_WORDS * 4 - 1)) == BUF_BASE;
    endfunction

    assign wrFire = axiReq.awvalid && axiReq.wvalid && !bvalid;
    assign rdFire = axiReq.arvalid && !rdPend && !rvalid;
    assign rdAddr = axiReq.araddr[WORD_ADDR_W+1:2];  // Buffer read starts with the handshake

    assign axiResp.awready = !bvalid;
    assign axiResp.wready = !bvalid;
    assign axiResp.bvalid = bvalid;
    assign axiResp.bresp = 2'b00;
    assign axiResp.arready = !rdPend && !rvalid;
    assign axiResp.rvalid = rvalid;
    assign axiResp.rdata = rdataR;
    assign axiResp.rresp = 2'b00;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            rdPend <= 1'b0;
            start <= 1'b0;
            blockNum <= '0;
        end else begin
            start <= 1'b0;
            if (wrFire) begin
                bvalid <= 1'b1;
                if (axiReq.awaddr == REG_CTRL && axiReq.wstrb[0] && axiReq.wdata[0] && !busy) begin
                    start <= 1'b1;
                end
                if (axiReq.awaddr == REG_BLOCK) begin
                    for (int i = 0; i < 4; i++) begin
                        if (axiReq.wstrb[i]) blockNum[8*i +: 8] <= axiReq.wdata[8*i +: 8];
                    end
                end
            end else if (axiReq.bready) begin
                bvalid <= 1'b0;
            end
            if (rdFire) begin
                rdPend <= 1'b1;
            end else if (rdPend) begin
                rdPend <= 1'b0;
                rvalid <= 1'b1;
            end else if (axiReq.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            rdSel <= axiReq.araddr;
        end
        if (rdPend) begin
            if (inBuffer(rdSel)) begin
                rdataR <= rdData;
            end else begin
                case (rdSel)
                    REG_BLOCK: rdataR <= blockNum;
                    REG_STATUS: rdataR <= {29'd0, error, done, busy};
                    default: rdataR <= '0;   // CTRL reads back zero
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) bvalid && !axiReq.bready |=> bvalid);
    assert property (@(posedge clk) disable iff (!rstN)
        rvalid && !axiReq.rready |=> rvalid && $stable(rdataR));

endmodule

// File: blockBuffer.sv
module blockBuffer import sdPkg::*; (
    input  logic                   clk,
    input  logic                   wrEn,
    input  logic [WORD_ADDR_W-1:0] wrAddr,
    input  logic [31:0]            wrData,
    input  logic [WORD_ADDR_W-1:0] rdAddr,
    output logic [31:0]            rdData
);
    logic [31:0] mem [BLOCK_WORDS];

    // Power-up contents read as zero
    initial begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];
    end

endmodule

// File: sdController.sv
module sdController import sdPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  logic [31:0]            blockNum,
    output logic                   busy,
    output logic                   done,
    output logic                   error,
    output spiJob_t                job,
    output logic                   jobValid,
    input  logic                   jobBusy,
    input  logic                   jobDone,
    input  logic [39:0]            respData,
    input  logic                   timedOut,
    input  logic                   byteValid,
    input  logic [7:0]             rxByte,
    output logic                   wrEn,
    output logic [WORD_ADDR_W-1:0] wrAddr,
    output logic [31:0]            wrData
);
    ctrlState_e             state;
    logic                   waiting;
    logic [7:0]             tokenCnt;
    logic [WORD_ADDR_W-1:0] wordCnt;
    logic [1:0]             byteIdx;
    logic [31:0]            blockLat;
    logic [23:0]            packReg;
    logic [7:0]             r1;

    assign r1 = respData[7:0];
    assign busy = !(state inside {ST_IDLE, ST_DONE, ST_ERROR});
    assign done = (state == ST_DONE);
    assign error = (state == ST_ERROR);

    function automatic spiJob_t cmdJob(input sdCmd_e cmd, input logic [31:0] arg,
                                       input logic [7:0] crcEnd, input logic [2:0] rxBytes);
        spiJob_t j;
        j.frame.startIdx = {2'b01, cmd};
        j.frame.arg = arg;
        j.frame.crcEnd = crcEnd;
        j.send = 1'b1;
        j.rxBytes = rxBytes;
        return j;
    endfunction

    always_comb begin
        job = cmdJob(CMD0, 32'h0, 8'h95, 3'd1);
        case (state)
            ST_CMD8: job = cmdJob(CMD8, 32'h0000_01AA, 8'h87, 3'd5);  // R7 is five bytes
            ST_CMD55: job = cmdJob(CMD55, 32'h0, 8'h65, 3'd1);
            ST_ACMD41: job = cmdJob(ACMD41, 32'h4000_0000, 8'h77, 3'd1);  // HCS set
            ST_CMD16: job = cmdJob(CMD16, 32'h0000_0200, 8'h15, 3'd1);
            ST_CMD17: job = cmdJob(CMD17, blockLat, 8'hFF, 3'd1);
            ST_TOKEN: job.send = 1'b0;
            ST_DATA: begin
                job.send = 1'b0;
                job.rxBytes = 3'd4;
            end
            ST_CRC: begin
                job.send = 1'b0;
                job.rxBytes = 3'd2;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= ST_IDLE;
            waiting <= 1'b0;
            jobValid <= 1'b0;
            wrEn <= 1'b0;
            tokenCnt <= '0;
            wordCnt <= '0;
            byteIdx <= '0;
        end else begin
            jobValid <= 1'b0;
            wrEn <= 1'b0;
            if (!busy) begin
                waiting <= 1'b0;
                if (start) begin
                    state <= ST_CMD0;
                end
            end else if (!waiting) begin
                if (!jobBusy) begin
                    jobValid <= 1'b1;
                    waiting <= 1'b1;
                end
            end else if (jobDone) begin
                waiting <= 1'b0;
                if (timedOut) begin
                    state <= ST_ERROR;
                end else begin
                    case (state)
                        ST_CMD0: if (r1 == 8'h01) state <= ST_CMD8;  // Else resend CMD0
                        ST_CMD8: begin
                            if (respData == 40'h01_0000_01AA) state <= ST_CMD55;
                            else state <= ST_ERROR;
                        end
                        ST_CMD55: state <= (r1[7:1] == 7'd0) ? ST_ACMD41 : ST_ERROR;
                        ST_ACMD41: begin
                            if (r1 == 8'h00) state <= ST_CMD16;
                            else if (r1 == 8'h01) state <= ST_CMD55;  // Card still busy
                            else state <= ST_ERROR;
                        end
                        ST_CMD16: state <= (r1 == 8'h00) ? ST_CMD17 : ST_ERROR;
                        ST_CMD17: begin
                            tokenCnt <= '0;
                            state <= (r1 == 8'h00) ? ST_TOKEN : ST_ERROR;
                        end
                        ST_TOKEN: begin
                            tokenCnt <= tokenCnt + 1'b1;
                            if (r1 == 8'hFE) begin
                                wordCnt <= '0;
                                byteIdx <= '0;
                                state <= ST_DATA;
                            end else if (tokenCnt == 8'(TOKEN_TIMEOUT_BYTES - 1)) begin
                                state <= ST_ERROR;
                            end
                        end
                        ST_DATA: if (wordCnt == '0) state <= ST_CRC;  // Wrapped after last word
                        ST_CRC: state <= ST_DONE;
                        default: state <= ST_ERROR;
                    endcase
                end
            end
            if (state == ST_DATA && byteValid) begin
                byteIdx <= byteIdx + 1'b1;
                if (byteIdx == 2'd3) begin
                    wrEn <= 1'b1;
                    wordCnt <= wordCnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            blockLat <= blockNum;
        end
        if (state == ST_DATA && byteValid) begin
            packReg <= {packReg[15:0], rxByte};
            if (byteIdx == 2'd3) begin
                wrData <= {packReg, rxByte};   // First byte lands in 31:24
                wrAddr <= wordCnt;
            end
        end
    end

endmodule

// File: spiShifter.sv
module spiShifter import sdPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  spiJob_t     job,
    input  logic        jobValid,
    output logic        jobBusy,
    output logic        jobDone,
    output logic [39:0] respData,
    output logic        timedOut,
    output logic        byteValid,
    output logic [7:0]  rxByte,
    output logic        sdClk,
    output logic        sdCs,
    output logic        sdMosi,
    input  logic        sdMiso
);
    typedef enum logic [2:0] {PH_IDLE, PH_LEAD, PH_SEND, PH_HUNT, PH_RECV} phase_e;

    phase_e      phase;
    logic [7:0]  divCnt;
    logic        tick;
    logic [3:0]  leadCnt;
    logic [5:0]  bitCnt;
    logic [3:0]  huntCnt;
    logic [2:0]  bytesLeft;
    logic        sendJob;
    logic [47:0] txShift;

    assign tick = (divCnt == 8'(CLK_DIV - 1));  // One sdClk half period
    assign jobBusy = (phase != PH_IDLE);

    always_ff @(posedge clk) begin
        if (!rstN || tick) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= PH_IDLE;
            sdClk <= 1'b0;
            sdCs <= 1'b1;
            sdMosi <= 1'b1;
            jobDone <= 1'b0;
            timedOut <= 1'b0;
            byteValid <= 1'b0;
            rxByte <= '0;
            respData <= '0;
            leadCnt <= '0;
            bitCnt <= '0;
            huntCnt <= '0;
            bytesLeft <= '0;
            sendJob <= 1'b0;
            txShift <= '0;
        end else begin
            jobDone <= 1'b0;
            byteValid <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    sdCs <= 1'b1;
                    sdMosi <= 1'b1;
                    sdClk <= 1'b0;
                    if (jobValid) begin
                        txShift <= job.frame;
                        sendJob <= job.send;
                        bytesLeft <= job.rxBytes;
                        leadCnt <= '0;
                        timedOut <= 1'b0;
                        phase <= PH_LEAD;
                    end
                end
                PH_LEAD: if (tick) begin
                    sdClk <= ~sdClk;            // Dummy clocks with CS high
                    leadCnt <= leadCnt + 1'b1;
                    if (leadCnt == 4'd15) begin
                        sdCs <= 1'b0;
                        bitCnt <= '0;
                        huntCnt <= '0;
                        if (sendJob) begin
                            sdMosi <= txShift[47];
                            txShift <= {txShift[46:0], 1'b1};
                            phase <= PH_SEND;
                        end else begin
                            phase <= PH_RECV;
                        end
                    end
                end
                PH_SEND: if (tick) begin
                    sdClk <= ~sdClk;
                    if (!sdClk) begin
                        bitCnt <= bitCnt + 1'b1;  // Card samples on rise
                    end else if (bitCnt == 6'd48) begin
                        sdMosi <= 1'b1;
                        bitCnt <= '0;
                        phase <= PH_HUNT;
                    end else begin
                        sdMosi <= txShift[47];
                        txShift <= {txShift[46:0], 1'b1};
                    end
                end
                PH_HUNT: if (tick) begin
                    sdClk <= ~sdClk;
                    if (!sdClk) begin
                        if (bitCnt[2:0] == 3'd0 && !sdMiso) begin
                            respData <= {respData[38:0], 1'b0};
                            bitCnt <= 6'd1;
                            phase <= PH_RECV;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt[2:0] == 3'd7) begin
                                huntCnt <= huntCnt + 1'b1;
                                if (huntCnt == 4'(RESP_TIMEOUT_BYTES - 1)) begin
                                    timedOut <= 1'b1;
                                    bytesLeft <= '0;  // Finish on next fall
                                    phase <= PH_RECV;
                                end
                            end
                        end
                    end
                end
                PH_RECV: if (tick) begin
                    sdClk <= ~sdClk;
                    if (!sdClk) begin
                        respData <= {respData[38:0], sdMiso};
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt[2:0] == 3'd7) begin
                            rxByte <= {respData[6:0], sdMiso};
                            byteValid <= 1'b1;
                            bytesLeft <= bytesLeft - 1'b1;
                        end
                    end else if (bytesLeft == '0) begin
                        jobDone <= 1'b1;        // CS rises in idle
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // Controller must wait for the previous job to finish
    assert property (@(posedge clk) disable iff (!rstN) jobValid |-> !jobBusy);

endmodule

// File: sdPkg.sv
package sdPkg;

    localparam int CLK_DIV = 4;               // System clocks per sdClk half period
    localparam int BLOCK_WORDS = 128;
    localparam int WORD_ADDR_W = 7;
    localparam int RESP_TIMEOUT_BYTES = 8;
    localparam int TOKEN_TIMEOUT_BYTES = 256;

    localparam logic [31:0] REG_CTRL = 32'h0000_0000;
    localparam logic [31:0] REG_BLOCK = 32'h0000_0004;
    localparam logic [31:0] REG_STATUS = 32'h0000_0008;
    localparam logic [31:0] BUF_BASE = 32'h0000_0200;

    typedef enum logic [5:0] {
        CMD0 = 6'd0,
        CMD8 = 6'd8,
        CMD16 = 6'd16,
        CMD17 = 6'd17,
        ACMD41 = 6'd41,
        CMD55 = 6'd55
    } sdCmd_e;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_CMD0,
        ST_CMD8,
        ST_CMD55,
        ST_ACMD41,
        ST_CMD16,
        ST_CMD17,
        ST_TOKEN,
        ST_DATA,
        ST_CRC,
        ST_DONE,
        ST_ERROR
    } ctrlState_e;

    typedef struct packed {
        logic [7:0] startIdx;                 // 01 plus command index
        logic [31:0] arg;
        logic [7:0] crcEnd;                   // CRC7 and end bit
    } sdCmdFrame_t;

    typedef struct packed {
        sdCmdFrame_t frame;
        logic send;
        logic [2:0] rxBytes;                  // 1 to 5
    } spiJob_t;

    typedef struct packed {
        logic [31:0] awaddr;
        logic awvalid;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic wvalid;
        logic bready;
        logic [31:0] araddr;
        logic arvalid;
        logic rready;
    } axiLiteReq_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [31:0] rdata;
        logic [1:0] rresp;
    } axiLiteResp_t;

endpackage
